// File: source/la_pipe_pkg.sv
`default_nettype none

package la_pipe_pkg;

    localparam int exc_w = 7;

    // Bit positions in the exception bundle.
    localparam int exc_ale  = 6;
    localparam int exc_adef = 5;
    localparam int exc_ine  = 4;
    localparam int exc_sys  = 3;
    localparam int exc_brk  = 2;
    localparam int exc_int  = 1;
    localparam int exc_ertn = 0;

    localparam logic [5:0] ecode_int  = 6'h00;
    localparam logic [5:0] ecode_adef = 6'h08;
    localparam logic [5:0] ecode_ale  = 6'h09;
    localparam logic [5:0] ecode_sys  = 6'h0B;
    localparam logic [5:0] ecode_brk  = 6'h0C;
    localparam logic [5:0] ecode_ine  = 6'h0D;

    localparam int mem_op_w = 3;

    localparam logic [mem_op_w-1:0] mop_none = 3'd0;
    localparam logic [mem_op_w-1:0] mop_ldw  = 3'd1;
    localparam logic [mem_op_w-1:0] mop_ldb  = 3'd2;  // Sign-extended.
    localparam logic [mem_op_w-1:0] mop_ldbu = 3'd3;  // Zero-extended.
    localparam logic [mem_op_w-1:0] mop_stw  = 3'd4;
    localparam logic [mem_op_w-1:0] mop_stb  = 3'd5;

    localparam logic [31:0] eentry_addr = 32'h1C00_8000;

    localparam int ram_aw = 8;

endpackage

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire         clk,
    input  wire  [4:0]  raddr1,
    input  wire  [4:0]  raddr2,
    input  wire         we,
    input  wire  [4:0]  waddr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register 0 reads as zero.
    assign rdata1 = (raddr1 == 5'd0) ? 32'b0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'b0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              es_to_ms_valid,
    input  wire [31:0]                       es_pc,
    input  wire [la_pipe_pkg::mem_op_w-1:0]  es_mem_op,
    input  wire [31:0]                       es_addr,
    input  wire [31:0]                       es_st_data,
    input  wire                              es_rf_we,
    input  wire [4:0]                        es_rf_waddr,
    input  wire [31:0]                       es_result,
    input  wire [la_pipe_pkg::exc_w-1:0]     es_exc,
    input  wire                              ws_allowin,
    input  wire                              flush,
    input  wire [31:0]                       wb_dat_r,
    input  wire                              wb_ack,
    output logic                             ms_allowin,
    output logic                             ms_to_ws_valid,
    output logic [31:0]                      ms_pc,
    output logic                             ms_rf_we,
    output logic [4:0]                       ms_rf_waddr,
    output logic [31:0]                      ms_rf_wdata,
    output logic [la_pipe_pkg::exc_w-1:0]    ms_exc,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [31:0]                      wb_adr,
    output logic [3:0]                       wb_sel,
    output logic [31:0]                      wb_dat_w
);

    logic                            ms_valid;
    logic                            ms_up;
    logic                            ms_ready_go;
    logic [la_pipe_pkg::mem_op_w-1:0] ms_mem_op;
    logic [31:0]                     ms_addr;
    logic [31:0]                     ms_st_data;
    logic [31:0]                     ms_result;
    logic [la_pipe_pkg::exc_w-1:0]   ms_exc_q;
    logic [7:0]                      ld_byte;
    logic                            is_load;
    logic                            is_store;
    logic                            is_word;
    logic                            mem_req;

    assign is_load  = (ms_mem_op == la_pipe_pkg::mop_ldw) | (ms_mem_op == la_pipe_pkg::mop_ldb)
                    | (ms_mem_op == la_pipe_pkg::mop_ldbu);
    assign is_store = (ms_mem_op == la_pipe_pkg::mop_stw) | (ms_mem_op == la_pipe_pkg::mop_stb);
    assign is_word  = (ms_mem_op == la_pipe_pkg::mop_ldw) | (ms_mem_op == la_pipe_pkg::mop_stw);

    always_comb begin
        ms_exc = ms_exc_q;
        ms_exc[la_pipe_pkg::exc_ale] = is_word & (ms_addr[1:0] != 2'b00);  // Misaligned word.
    end

    // Access only for a clean instruction.
    assign mem_req     = ms_valid & (is_load | is_store) & ~(|ms_exc);
    assign ms_ready_go = ~mem_req | wb_ack;

    assign ms_allowin     = ms_up & ~flush & (~ms_valid | (ms_ready_go & ws_allowin));
    assign ms_to_ws_valid = ms_valid & ms_ready_go & ~flush;

    assign wb_cyc   = mem_req & ~flush;  // Killed access never starts.
    assign wb_stb   = mem_req & ~flush;
    assign wb_we    = is_store;
    assign wb_adr   = ms_addr;
    assign wb_sel   = is_word ? 4'hF : (4'b0001 << ms_addr[1:0]);
    assign wb_dat_w = is_word ? ms_st_data : {4{ms_st_data[7:0]}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_up    <= 1'b0;
            ms_valid <= 1'b0;
        end else begin
            ms_up <= 1'b1;
            if (flush) begin
                ms_valid <= 1'b0;
            end else if (ms_allowin) begin
                ms_valid <= es_to_ms_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ms_allowin & es_to_ms_valid) begin
            ms_pc       <= es_pc;
            ms_mem_op   <= es_mem_op;
            ms_addr     <= es_addr;
            ms_st_data  <= es_st_data;
            ms_rf_we    <= es_rf_we;
            ms_rf_waddr <= es_rf_waddr;
            ms_result   <= es_result;
            ms_exc_q    <= es_exc;
        end
    end

    assign ld_byte = wb_dat_r[ms_addr[1:0]*8 +: 8];

    always_comb begin
        case (ms_mem_op)
            la_pipe_pkg::mop_ldw:  ms_rf_wdata = wb_dat_r;
            la_pipe_pkg::mop_ldb:  ms_rf_wdata = {{24{ld_byte[7]}}, ld_byte};
            la_pipe_pkg::mop_ldbu: ms_rf_wdata = {24'b0, ld_byte};
            default:               ms_rf_wdata = ms_result;
        endcase
    end

endmodule

`default_nettype wire

// File: source/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire                             ms_to_ws_valid,
    input  wire [31:0]                      ms_pc,
    input  wire                             ms_rf_we,
    input  wire [4:0]                       ms_rf_waddr,
    input  wire [31:0]                      ms_rf_wdata,
    input  wire [la_pipe_pkg::exc_w-1:0]    ms_exc,
    output logic                            ws_allowin,
    output logic                            rf_we,
    output logic [4:0]                      rf_waddr,
    output logic [31:0]                     rf_wdata,
    output logic [31:0]                     ws_pc,
    output logic [la_pipe_pkg::exc_w-1:0]   ws_exc_bits,
    output logic                            ws_exc,
    output logic                            ertn_flush,
    output logic [31:0]                     debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [4:0]                      debug_wb_rf_wnum,
    output logic [31:0]                     debug_wb_rf_wdata
);

    logic ws_valid;
    logic ws_ready_go;
    logic ws_rf_we;
    logic ale_exc;
    logic adef_exc;
    logic ine_exc;
    logic sys_exc;
    logic brk_exc;
    logic int_exc;
    logic ertn_bit;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = ~ws_valid | ws_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid & ws_allowin) begin
            ws_pc       <= ms_pc;
            ws_rf_we    <= ms_rf_we;
            rf_waddr    <= ms_rf_waddr;
            rf_wdata    <= ms_rf_wdata;
            ws_exc_bits <= ms_exc;
        end
    end

    assign {ale_exc, adef_exc, ine_exc, sys_exc, brk_exc, int_exc, ertn_bit} = ws_exc_bits;

    assign ws_exc     = ws_valid & (ale_exc | adef_exc | ine_exc | sys_exc | brk_exc | int_exc);
    assign ertn_flush = ws_valid & ertn_bit;

    assign rf_we = ws_valid & ws_rf_we & ~(|ws_exc_bits);  // No write on exception or ertn.

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

// File: source/exc_csr.sv
`timescale 1ns/1ns
`default_nettype none

module exc_csr (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire                            ws_exc,
    input  wire                            ertn_flush,
    input  wire [31:0]                     ws_pc,
    input  wire [la_pipe_pkg::exc_w-1:0]   ws_exc_bits,
    output logic                           flush,
    output logic [31:0]                    flush_target,
    output logic [31:0]                    csr_era,
    output logic [5:0]                     csr_ecode
);

    logic [5:0] exc_ecode;

    always_comb begin
        if (ws_exc_bits[la_pipe_pkg::exc_int]) begin
            exc_ecode = la_pipe_pkg::ecode_int;
        end else if (ws_exc_bits[la_pipe_pkg::exc_adef]) begin
            exc_ecode = la_pipe_pkg::ecode_adef;
        end else if (ws_exc_bits[la_pipe_pkg::exc_ine]) begin
            exc_ecode = la_pipe_pkg::ecode_ine;
        end else if (ws_exc_bits[la_pipe_pkg::exc_sys]) begin
            exc_ecode = la_pipe_pkg::ecode_sys;
        end else if (ws_exc_bits[la_pipe_pkg::exc_brk]) begin
            exc_ecode = la_pipe_pkg::ecode_brk;
        end else begin
            exc_ecode = la_pipe_pkg::ecode_ale;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            csr_era   <= 32'b0;
            csr_ecode <= 6'b0;
        end else if (ws_exc) begin
            csr_era   <= ws_pc;
            csr_ecode <= exc_ecode;
        end
    end

    assign flush        = ws_exc | ertn_flush;
    assign flush_target = ws_exc ? la_pipe_pkg::eentry_addr : csr_era;  // Exception wins.

endmodule

`default_nettype wire

// File: source/data_ram_wb.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram_wb (
    input  wire         clk,
    input  wire         resetn,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [31:0] wb_adr,
    input  wire  [3:0]  wb_sel,
    input  wire  [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    logic [31:0] mem [0:(1<<la_pipe_pkg::ram_aw)-1];
    logic [la_pipe_pkg::ram_aw-1:0] idx;
    logic        take;

    initial begin
        for (int i = 0; i < (1 << la_pipe_pkg::ram_aw); i++) begin
            mem[i] = 32'b0;
        end
    end

    assign idx  = wb_adr[la_pipe_pkg::ram_aw+1:2];
    assign take = wb_cyc & wb_stb & ~wb_ack;  // One wait state.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_dat_r <= mem[idx];
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) begin
                        mem[idx][b*8 +: 8] <= wb_dat_w[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pipe_tail_top.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_tail_top (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              es_to_ms_valid,
    input  wire [31:0]                       es_pc,
    input  wire [la_pipe_pkg::mem_op_w-1:0]  es_mem_op,
    input  wire [31:0]                       es_addr,
    input  wire [31:0]                       es_st_data,
    input  wire                              es_rf_we,
    input  wire [4:0]                        es_rf_waddr,
    input  wire [31:0]                       es_result,
    input  wire [la_pipe_pkg::exc_w-1:0]     es_exc,
    output logic                             ms_allowin,
    input  wire [4:0]                        rf_raddr1,
    input  wire [4:0]                        rf_raddr2,
    output logic [31:0]                      rf_rdata1,
    output logic [31:0]                      rf_rdata2,
    output logic [31:0]                      debug_wb_pc,
    output logic [3:0]                       debug_wb_rf_we,
    output logic [4:0]                       debug_wb_rf_wnum,
    output logic [31:0]                      debug_wb_rf_wdata,
    output logic                             flush,
    output logic [31:0]                      flush_target,
    output logic [31:0]                      csr_era,
    output logic [5:0]                       csr_ecode
);

    logic                          ws_allowin;
    logic                          ms_to_ws_valid;
    logic [31:0]                   ms_pc;
    logic                          ms_rf_we;
    logic [4:0]                    ms_rf_waddr;
    logic [31:0]                   ms_rf_wdata;
    logic [la_pipe_pkg::exc_w-1:0] ms_exc;
    logic                          rf_we;
    logic [4:0]                    rf_waddr;
    logic [31:0]                   rf_wdata;
    logic [31:0]                   ws_pc;
    logic [la_pipe_pkg::exc_w-1:0] ws_exc_bits;
    logic                          ws_exc;
    logic                          ertn_flush;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [31:0]                   wb_adr;
    logic [3:0]                    wb_sel;
    logic [31:0]                   wb_dat_w;
    logic [31:0]                   wb_dat_r;
    logic                          wb_ack;

    mem_stage u_mem_stage (
        .clk            (clk),
        .resetn         (resetn),
        .es_to_ms_valid (es_to_ms_valid),
        .es_pc          (es_pc),
        .es_mem_op      (es_mem_op),
        .es_addr        (es_addr),
        .es_st_data     (es_st_data),
        .es_rf_we       (es_rf_we),
        .es_rf_waddr    (es_rf_waddr),
        .es_result      (es_result),
        .es_exc         (es_exc),
        .ws_allowin     (ws_allowin),
        .flush          (flush),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .ms_allowin     (ms_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_pc          (ms_pc),
        .ms_rf_we       (ms_rf_we),
        .ms_rf_waddr    (ms_rf_waddr),
        .ms_rf_wdata    (ms_rf_wdata),
        .ms_exc         (ms_exc),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_sel         (wb_sel),
        .wb_dat_w       (wb_dat_w)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_pc             (ms_pc),
        .ms_rf_we          (ms_rf_we),
        .ms_rf_waddr       (ms_rf_waddr),
        .ms_rf_wdata       (ms_rf_wdata),
        .ms_exc            (ms_exc),
        .ws_allowin        (ws_allowin),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .ws_pc             (ws_pc),
        .ws_exc_bits       (ws_exc_bits),
        .ws_exc            (ws_exc),
        .ertn_flush        (ertn_flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    exc_csr u_exc_csr (
        .clk          (clk),
        .resetn       (resetn),
        .ws_exc       (ws_exc),
        .ertn_flush   (ertn_flush),
        .ws_pc        (ws_pc),
        .ws_exc_bits  (ws_exc_bits),
        .flush        (flush),
        .flush_target (flush_target),
        .csr_era      (csr_era),
        .csr_ecode    (csr_ecode)
    );

    data_ram_wb u_data_ram_wb (
        .clk      (clk),
        .resetn   (resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

// File: verif/tb_pipe_tail_ref.svh
`ifndef TB_PIPE_TAIL_REF_SVH
`define TB_PIPE_TAIL_REF_SVH

// Fibonacci LFSR with taps 32 22 2 1.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = 32'h0;
    for (int k = 0; k < n; k++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

// Expected bundle and write data. A clean store also updates the memory mirror.
function automatic void ref_result(
    input  logic [la_pipe_pkg::mem_op_w-1:0] op,
    input  logic [31:0]                      addr,
    input  logic [31:0]                      st_data,
    input  logic [31:0]                      result,
    input  logic [la_pipe_pkg::exc_w-1:0]    exc_in,
    output logic [la_pipe_pkg::exc_w-1:0]    exc_out,
    output logic [31:0]                      wdata
);
    logic [la_pipe_pkg::ram_aw-1:0] idx;
    logic [31:0]                    word;
    logic [7:0]                     lane;
    idx     = addr[la_pipe_pkg::ram_aw+1:2];
    word    = mem_mirror[idx];
    lane    = word[addr[1:0]*8 +: 8];
    exc_out = exc_in;
    wdata   = result;
    if ((op == la_pipe_pkg::mop_ldw || op == la_pipe_pkg::mop_stw) && addr[1:0] != 2'b00) begin
        exc_out[la_pipe_pkg::exc_ale] = 1'b1;  // Word access off a word boundary.
    end
    if (exc_out == '0) begin
        case (op)
            la_pipe_pkg::mop_ldw:  wdata = word;
            la_pipe_pkg::mop_ldb:  wdata = {{24{lane[7]}}, lane};
            la_pipe_pkg::mop_ldbu: wdata = {24'h0, lane};
            la_pipe_pkg::mop_stw:  mem_mirror[idx] = st_data;
            la_pipe_pkg::mop_stb:  mem_mirror[idx][addr[1:0]*8 +: 8] = st_data[7:0];
            default: ;
        endcase
    end
endfunction

// Priority order is int, adef, ine, sys, brk, ale.
function automatic logic [5:0] pick_ecode(input logic [la_pipe_pkg::exc_w-1:0] e);
    if (e[la_pipe_pkg::exc_int])  return la_pipe_pkg::ecode_int;
    if (e[la_pipe_pkg::exc_adef]) return la_pipe_pkg::ecode_adef;
    if (e[la_pipe_pkg::exc_ine])  return la_pipe_pkg::ecode_ine;
    if (e[la_pipe_pkg::exc_sys])  return la_pipe_pkg::ecode_sys;
    if (e[la_pipe_pkg::exc_brk])  return la_pipe_pkg::ecode_brk;
    return la_pipe_pkg::ecode_ale;
endfunction

`endif

// File: verif/tb_pipe_tail.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_tail;

    localparam int n_rand  = 60;
    localparam int n_issue = n_rand + 15;

    localparam logic [6:0] x_int  = 7'd1 << la_pipe_pkg::exc_int;
    localparam logic [6:0] x_adef = 7'd1 << la_pipe_pkg::exc_adef;
    localparam logic [6:0] x_ine  = 7'd1 << la_pipe_pkg::exc_ine;
    localparam logic [6:0] x_sys  = 7'd1 << la_pipe_pkg::exc_sys;
    localparam logic [6:0] x_brk  = 7'd1 << la_pipe_pkg::exc_brk;
    localparam logic [6:0] x_ertn = 7'd1 << la_pipe_pkg::exc_ertn;

    logic                             clk;
    logic                             resetn;
    logic                             es_to_ms_valid;
    logic [31:0]                      es_pc;
    logic [la_pipe_pkg::mem_op_w-1:0] es_mem_op;
    logic [31:0]                      es_addr;
    logic [31:0]                      es_st_data;
    logic                             es_rf_we;
    logic [4:0]                       es_rf_waddr;
    logic [31:0]                      es_result;
    logic [la_pipe_pkg::exc_w-1:0]    es_exc;
    logic                             ms_allowin;
    logic [4:0]                       rf_raddr1;
    logic [4:0]                       rf_raddr2;
    logic [31:0]                      rf_rdata1;
    logic [31:0]                      rf_rdata2;
    logic [31:0]                      debug_wb_pc;
    logic [3:0]                       debug_wb_rf_we;
    logic [4:0]                       debug_wb_rf_wnum;
    logic [31:0]                      debug_wb_rf_wdata;
    logic                             flush;
    logic [31:0]                      flush_target;
    logic [31:0]                      csr_era;
    logic [5:0]                       csr_ecode;

    logic [31:0] lfsr;
    logic [31:0] mem_mirror [0:(1<<la_pipe_pkg::ram_aw)-1];
    logic [31:0] reg_mirror [0:31];
    logic        reg_written [0:31];
    logic [68:0] wr_q [$];  // {pc, wnum, wdata}.
    logic [38:0] fl_q [$];  // {pc, ertn, ecode}.
    logic [68:0] wr_exp;
    logic [38:0] fl_exp;
    logic [31:0] exp_era;
    logic [5:0]  exp_ecode;
    logic [31:0] pc;
    logic [2:0]  r_sel;
    logic [2:0]  r_op;
    logic [31:0] r_addr;
    int          errors;
    int          wr_checked;
    int          fl_checked;
    int          flush_rejects;
    int          issued;

    `include "tb_pipe_tail_ref.svh"

    pipe_tail_top u_pipe_tail_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((20 * n_issue + 100) * 10);
        $display("Timeout with %0d errors, %0d writes and %0d flushes pending",
                 errors, wr_q.size(), fl_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        errors++;
        $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    endtask

    task automatic issue_instr(
        input logic [la_pipe_pkg::mem_op_w-1:0] op,
        input logic [31:0]                      addr,
        input logic [31:0]                      st_data,
        input logic                             rf_we,
        input logic [4:0]                       waddr,
        input logic [31:0]                      result,
        input logic [la_pipe_pkg::exc_w-1:0]    exc
    );
        logic [la_pipe_pkg::exc_w-1:0] exc_exp;
        logic [31:0]                   wdata_exp;
        logic                          taken;
        pc = pc + 32'd4;
        ref_result(op, addr, st_data, result, exc, exc_exp, wdata_exp);
        if (exc_exp != '0) begin
            fl_q.push_back({pc, exc_exp == x_ertn, pick_ecode(exc_exp)});
        end else if (rf_we) begin
            wr_q.push_back({pc, waddr, wdata_exp});
            if (waddr != 5'd0) begin
                reg_mirror[waddr]  = wdata_exp;
                reg_written[waddr] = 1'b1;
            end
        end
        es_to_ms_valid = 1'b1;
        es_pc          = pc;
        es_mem_op      = op;
        es_addr        = addr;
        es_st_data     = st_data;
        es_rf_we       = rf_we;
        es_rf_waddr    = waddr;
        es_result      = result;
        es_exc         = exc;
        taken          = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = ms_allowin;
            if (flush) begin
                flush_rejects++;
                if (ms_allowin) begin
                    errors++;
                    $display("At %0t the memory stage accepts during a flush", $time);
                end
            end
            @(posedge clk);
            #1;
        end
        es_to_ms_valid = 1'b0;
        issued++;
        if (exc_exp != '0) begin
            @(posedge clk);  // Next offer falls in the flush cycle.
            #1;
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            rf_raddr1 = r;
            rf_raddr2 = 31 - r;
            @(negedge clk);
            if (reg_written[r] && rf_rdata1 !== reg_mirror[r]) begin
                report_mismatch("rf_rdata1", rf_rdata1, reg_mirror[r]);
            end
            if (reg_written[31-r] && rf_rdata2 !== reg_mirror[31-r]) begin
                report_mismatch("rf_rdata2", rf_rdata2, reg_mirror[31-r]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (resetn) begin
            if (csr_era !== exp_era) report_mismatch("csr_era", csr_era, exp_era);
            if (csr_ecode !== exp_ecode) report_mismatch("csr_ecode", csr_ecode, exp_ecode);
            if (debug_wb_rf_we !== 4'h0) begin
                if (wr_q.size() == 0) begin
                    errors++;
                    $display("At %0t an unexpected register write to r%0d",
                             $time, debug_wb_rf_wnum);
                end else begin
                    wr_exp = wr_q.pop_front();
                    wr_checked++;
                    if (debug_wb_rf_we !== 4'hF) begin
                        report_mismatch("debug_wb_rf_we", debug_wb_rf_we, 4'hF);
                    end
                    if (debug_wb_pc !== wr_exp[68:37]) begin
                        report_mismatch("debug_wb_pc", debug_wb_pc, wr_exp[68:37]);
                    end
                    if (debug_wb_rf_wnum !== wr_exp[36:32]) begin
                        report_mismatch("debug_wb_rf_wnum", debug_wb_rf_wnum, wr_exp[36:32]);
                    end
                    if (debug_wb_rf_wdata !== wr_exp[31:0]) begin
                        report_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, wr_exp[31:0]);
                    end
                end
            end
            if (flush !== 1'b0) begin
                if (fl_q.size() == 0) begin
                    errors++;
                    $display("At %0t an unexpected flush from pc 0x%08h", $time, debug_wb_pc);
                end else begin
                    fl_exp = fl_q.pop_front();
                    fl_checked++;
                    if (debug_wb_pc !== fl_exp[38:7]) begin
                        report_mismatch("debug_wb_pc", debug_wb_pc, fl_exp[38:7]);
                    end
                    if (fl_exp[6]) begin
                        if (flush_target !== exp_era) begin
                            report_mismatch("flush_target", flush_target, exp_era);
                        end
                    end else begin
                        if (flush_target !== la_pipe_pkg::eentry_addr) begin
                            report_mismatch("flush_target", flush_target, la_pipe_pkg::eentry_addr);
                        end
                        exp_era   = fl_exp[38:7];  // CSRs follow at the edge.
                        exp_ecode = fl_exp[5:0];
                    end
                end
            end
        end
    end

    initial begin
        resetn         = 1'b0;
        es_to_ms_valid = 1'b0;
        es_pc          = 32'h0;
        es_mem_op      = la_pipe_pkg::mop_none;
        es_addr        = 32'h0;
        es_st_data     = 32'h0;
        es_rf_we       = 1'b0;
        es_rf_waddr    = 5'd0;
        es_result      = 32'h0;
        es_exc         = '0;
        rf_raddr1      = 5'd0;
        rf_raddr2      = 5'd0;
        lfsr           = 32'h5ce5;
        pc             = 32'h1C00_0000;
        exp_era        = 32'h0;
        exp_ecode      = 6'h0;
        errors         = 0;
        wr_checked     = 0;
        fl_checked     = 0;
        flush_rejects  = 0;
        issued         = 0;
        for (int a = 0; a < (1 << la_pipe_pkg::ram_aw); a++) begin
            mem_mirror[a] = 32'h0;
        end
        for (int r = 0; r < 32; r++) begin
            reg_mirror[r]  = 32'h0;
            reg_written[r] = (r == 0);
        end
        repeat (3) @(posedge clk);
        #1;
        if (ms_allowin !== 1'b0) report_mismatch("ms_allowin", ms_allowin, 0);
        if (flush !== 1'b0) report_mismatch("flush", flush, 0);
        if (debug_wb_rf_we !== 4'h0) report_mismatch("debug_wb_rf_we", debug_wb_rf_we, 0);
        if (csr_era !== 32'h0) report_mismatch("csr_era", csr_era, 0);
        if (csr_ecode !== 6'h0) report_mismatch("csr_ecode", csr_ecode, 0);
        resetn = 1'b1;

        // ALU results with one aimed at r0.
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd3, rand_bits(32), '0);
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd0, 32'hDEAD_BEEF, '0);
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd4, rand_bits(32), '0);
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd31, rand_bits(32), '0);

        for (int i = 0; i < n_rand; i++) begin
            r_sel = rand_bits(3) % 5;
            case (r_sel)
                3'd0:    r_op = la_pipe_pkg::mop_stw;
                3'd1:    r_op = la_pipe_pkg::mop_stb;
                3'd2:    r_op = la_pipe_pkg::mop_ldw;
                3'd3:    r_op = la_pipe_pkg::mop_ldb;
                default: r_op = la_pipe_pkg::mop_ldbu;
            endcase
            r_addr = 32'h100 + {rand_bits(4), 2'b00};
            if (r_op != la_pipe_pkg::mop_ldw && r_op != la_pipe_pkg::mop_stw) begin
                r_addr = r_addr + rand_bits(2);  // Byte lane.
            end
            issue_instr(r_op, r_addr, rand_bits(32), r_sel >= 3'd2, rand_bits(5), 32'h0, '0);
        end

        // Misaligned word accesses.
        issue_instr(la_pipe_pkg::mop_stw, 32'h180, 32'hA5A5_1234, 1'b0, 5'd0, 0, '0);
        issue_instr(la_pipe_pkg::mop_stw, 32'h182, 32'h0BAD_0BAD, 1'b1, 5'd7, 0, '0);
        issue_instr(la_pipe_pkg::mop_ldw, 32'h180, 0, 1'b1, 5'd8, 0, '0);
        issue_instr(la_pipe_pkg::mop_ldw, 32'h187, 0, 1'b1, 5'd9, 0, '0);

        // Several bits at once.
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd10, 32'h1111, x_sys | x_brk | x_ine);
        issue_instr(la_pipe_pkg::mop_ldw, 32'h181, 0, 1'b1, 5'd11, 0, x_brk);
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd12, 32'h2222, x_int | x_adef | x_sys);
        issue_instr(la_pipe_pkg::mop_stb, 32'h181, 32'hFF, 1'b0, 5'd0, 0, x_adef);
        issue_instr(la_pipe_pkg::mop_ldbu, 32'h181, 0, 1'b1, 5'd13, 0, '0);

        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd14, 32'h3333, x_ertn);
        issue_instr(la_pipe_pkg::mop_none, 0, 0, 1'b1, 5'd15, 32'h4444, '0);

        while (wr_q.size() != 0 || fl_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        check_regs();
        if (flush_rejects == 0) begin
            errors++;
            $display("No instruction was ever offered during a flush cycle");
        end
        $display("Issued %0d, checked %0d writes and %0d flushes, %0d errors",
                 issued, wr_checked, fl_checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verif
source/la_pipe_pkg.sv
source/reg_file.sv
source/mem_stage.sv
source/wb_stage.sv
source/exc_csr.sv
source/data_ram_wb.sv
source/pipe_tail_top.sv
verif/tb_pipe_tail.sv
